//--- l2_cache.f
+incdir+rtl
rtl/l2_pkg.sv
rtl/l2_way_slice.sv
rtl/l2_lru.sv
rtl/l2_mshr_queue.sv
rtl/l2_writeback.sv
rtl/l2_control.sv
rtl/l2_cache.sv
tb/tb_dram_model.sv
tb/tb_l2_cache.sv

//--- run_sim.sh
#!/bin/sh
# build and run the L2 cache testbench with Verilator

LOG=sim.log

verilator --binary --timing -f l2_cache.f --top-module tb_l2_cache -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- tb/tb_l2_cache.sv
`timescale 1ns/1ps
`include "l2_settings.svh"

module tb_l2_cache;
    import l2_pkg::*;

    localparam int NUM_ENTRIES = 22;
    localparam int CYCLE_LIMIT = 200 * NUM_ENTRIES;

    logic  clock, reset;
    logic  req_valid, req_write;
    addr_t req_addr;
    line_t req_data;
    logic  resp_valid, busy;
    addr_t resp_addr;
    line_t resp_data;
    logic  ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
    logic  w_valid, w_ready, b_valid, b_ready;
    addr_t ar_addr, aw_addr;
    line_t r_data, w_data;

    // stimulus table, one column per array
    logic  t_write [NUM_ENTRIES];
    addr_t t_addr  [NUM_ENTRIES];
    line_t t_data  [NUM_ENTRIES];
    logic  t_sync  [NUM_ENTRIES];     // drain and check counts after this entry
    logic  t_fast  [NUM_ENTRIES];     // response due 2 cycles after the strobe
    logic  t_burst [NUM_ENTRIES];     // first of a back-to-back miss group
    int    t_ar    [NUM_ENTRIES];     // running ar count after a sync
    int    t_aw    [NUM_ENTRIES];

    line_t ref_mem [2**`L2_ADDR_BITS];
    addr_t sb_addr [$];               // outstanding requests
    line_t sb_line [$];
    logic  sb_fast [$];
    int    sb_cycle [$];
    logic  req_fast;
    int    cycle_count, ar_count, aw_count, ar_base;
    addr_t last_ar_addr;              // address of the latest ar transfer
    logic  burst_armed;

    l2_cache uut (.*);

    tb_dram_model u_dram (
        .clock, .reset, .ar_valid, .ar_ready, .ar_addr, .r_valid, .r_ready, .r_data,
        .aw_valid, .aw_ready, .aw_addr, .w_valid, .w_ready, .w_data, .b_valid, .b_ready
    );

    always #5 clock = ~clock;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("** Error at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_with_failure($sformatf("** Error at %0t: %s is %0d, expected %0d",
                                        $time, what, got, exp));
        end
    endtask

    // DRAM rule: address in the low half, its inversion in the high half
    function automatic line_t dram_line(input addr_t a);
        return {~{16'h0000, a}, {16'h0000, a}};
    endfunction

    task automatic add_entry(input int i, input logic wr, input addr_t a, input line_t d,
                             input logic sync, input logic fast, input logic burst,
                             input int ar, input int aw);
        t_write[i] = wr;
        t_addr[i]  = a;
        t_data[i]  = d;
        t_sync[i]  = sync;
        t_fast[i]  = fast;
        t_burst[i] = burst;
        t_ar[i]    = ar;
        t_aw[i]    = aw;
    endtask

    task automatic fill_table();
        add_entry(0,  0, 16'h0011, '0, 1, 0, 0, 1, 0);     // cold read
        add_entry(1,  0, 16'h0011, '0, 1, 1, 0, 1, 0);     // hit
        add_entry(2,  1, 16'h0123, 64'h1122_3344_5566_7788, 1, 1, 0, 1, 0);
        add_entry(3,  0, 16'h0123, '0, 1, 1, 0, 1, 0);
        // five lines in set 5, then the oldest comes back
        add_entry(4,  0, 16'h0105, '0, 1, 0, 0, 2, 0);
        add_entry(5,  0, 16'h0205, '0, 1, 0, 0, 3, 0);
        add_entry(6,  0, 16'h0305, '0, 1, 0, 0, 4, 0);
        add_entry(7,  0, 16'h0405, '0, 1, 0, 0, 5, 0);
        add_entry(8,  0, 16'h0505, '0, 1, 0, 0, 6, 0);
        add_entry(9,  0, 16'h0105, '0, 1, 0, 0, 7, 0);
        add_entry(10, 0, 16'h0505, '0, 1, 1, 0, 7, 0);
        // dirty line in set 9 pushed out by four fills
        add_entry(11, 1, 16'h0a09, 64'hdead_beef_0bad_f00d, 1, 1, 0, 7, 0);
        add_entry(12, 0, 16'h0b09, '0, 1, 0, 0, 8, 0);
        add_entry(13, 0, 16'h0c09, '0, 1, 0, 0, 9, 0);
        add_entry(14, 0, 16'h0d09, '0, 1, 0, 0, 10, 0);
        add_entry(15, 0, 16'h0e09, '0, 1, 0, 0, 11, 1);
        add_entry(16, 0, 16'h0a09, '0, 1, 0, 0, 12, 1);
        // back-to-back misses, then a read of a pending line
        add_entry(17, 0, 16'h001a, '0, 0, 0, 1, 0, 0);
        add_entry(18, 0, 16'h002b, '0, 0, 0, 0, 0, 0);
        add_entry(19, 0, 16'h003c, '0, 0, 0, 0, 0, 0);
        add_entry(20, 0, 16'h004d, '0, 0, 0, 0, 0, 0);
        add_entry(21, 0, 16'h004d, '0, 1, 0, 0, 16, 1);
    endtask

    // ------------------------------------------------------------------------
    // monitor: scoreboard, channel counts and timeout
    // ------------------------------------------------------------------------
    always @(posedge clock) begin
        int idx;
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            stop_with_failure("timeout: the cache stopped answering within the cycle limit");
        end
        if (!reset) begin
            if (ar_valid && ar_ready) begin
                ar_count     = ar_count + 1;
                last_ar_addr = ar_addr;
            end
            if (aw_valid && aw_ready) begin
                aw_count = aw_count + 1;
                check_line(w_data, ref_mem[aw_addr], "write-back data");
            end
            if (r_valid && r_ready && burst_armed) begin
                check_count(ar_count - ar_base, 4, "ar transfers before first r");
                burst_armed = 1'b0;
            end
            if (req_valid) begin
                if (req_write) ref_mem[req_addr] = req_data;
                sb_addr.push_back(req_addr);
                sb_line.push_back(ref_mem[req_addr]);
                sb_fast.push_back(req_fast);
                sb_cycle.push_back(cycle_count);
            end
            if (resp_valid) begin
                idx = -1;
                for (int i = sb_addr.size() - 1; i >= 0; i--) begin
                    if (sb_addr[i] == resp_addr) idx = i;
                end
                if (idx < 0) begin
                    stop_with_failure($sformatf("response for address %h that was never requested",
                                                resp_addr));
                end
                check_line(resp_data, sb_line[idx], "response data");
                if (sb_fast[idx]) check_count(cycle_count - sb_cycle[idx], 2, "response latency");
                sb_addr.delete(idx);
                sb_line.delete(idx);
                sb_fast.delete(idx);
                sb_cycle.delete(idx);
            end
        end
    end

    task automatic apply_entry(input int i);
        int ar_before;
        do @(negedge clock); while (busy || (r_valid && r_ready));
        ar_before = ar_count;
        if (t_burst[i]) begin
            ar_base     = ar_count;
            burst_armed = 1'b1;
        end
        @(posedge clock);
        req_valid <= 1'b1;
        req_write <= t_write[i];
        req_addr  <= t_addr[i];
        req_data  <= t_data[i];
        req_fast  <= t_fast[i];
        @(posedge clock);
        req_valid <= 1'b0;
        if (t_sync[i]) begin
            do @(negedge clock);
            while (sb_addr.size() != 0 || busy || aw_valid || w_valid || b_ready);
            check_count(ar_count, t_ar[i], "ar transfer count");
            check_count(aw_count, t_aw[i], "aw transfer count");
            // a miss sends its own line address on ar
            if (t_ar[i] > ar_before) check_addr(last_ar_addr, t_addr[i], "ar address");
        end
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_data     = '0;
        req_fast     = 1'b0;
        cycle_count  = 0;
        ar_count     = 0;
        aw_count     = 0;
        ar_base      = 0;
        last_ar_addr = '0;
        burst_armed  = 1'b0;
        for (int a = 0; a < 2**`L2_ADDR_BITS; a++) ref_mem[a] = dram_line(addr_t'(a));
        fill_table();
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) apply_entry(i);
        $display("Test OK");
        $finish;
    end

endmodule

//--- tb/tb_dram_model.sv
`timescale 1ns/1ps
`include "l2_settings.svh"

module tb_dram_model (
    input  logic          clock,
    input  logic          reset,
    input  logic          ar_valid,
    output logic          ar_ready,
    input  l2_pkg::addr_t ar_addr,
    output logic          r_valid,
    input  logic          r_ready,
    output l2_pkg::line_t r_data,
    input  logic          aw_valid,
    output logic          aw_ready,
    input  l2_pkg::addr_t aw_addr,
    input  logic          w_valid,
    output logic          w_ready,
    input  l2_pkg::line_t w_data,
    output logic          b_valid,
    input  logic          b_ready
);
    import l2_pkg::*;

    line_t  mem [2**`L2_ADDR_BITS];
    addr_t  rd_addr_q [$];      // reads in ar order
    int     rd_time_q [$];      // earliest cycle for each r beat
    integer seed;
    int     now;
    int     b_wait;
    logic   got_aw;
    logic   got_w;
    addr_t  wr_addr;
    line_t  wr_line;

    initial begin
        seed     = 32'hca82_667e;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        for (int a = 0; a < 2**`L2_ADDR_BITS; a++) begin
            mem[a] = {~{16'h0000, addr_t'(a)}, {16'h0000, addr_t'(a)}};
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r_data   <= '0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            now      = 0;
            b_wait   = 0;
            got_aw   = 1'b0;
            got_w    = 1'b0;
            rd_addr_q.delete();
            rd_time_q.delete();
        end else begin
            now = now + 1;
            ar_ready <= 1'($random(seed));
            aw_ready <= 1'($random(seed));
            w_ready  <= 1'($random(seed));

            // ---------------------------------------------------------------------
            // read side, beats leave in ar order after a random latency
            // ---------------------------------------------------------------------
            if (ar_valid && ar_ready) begin
                rd_addr_q.push_back(ar_addr);
                rd_time_q.push_back(now + 24 + int'($unsigned($random(seed)) % 8));
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end else if (!r_valid && rd_addr_q.size() > 0 && now >= rd_time_q[0]) begin
                r_valid <= 1'b1;
                r_data  <= mem[rd_addr_q[0]];
                void'(rd_addr_q.pop_front());
                void'(rd_time_q.pop_front());
            end

            // ---------------------------------------------------------------------
            // write side, aw and w may arrive in either order
            // ---------------------------------------------------------------------
            if (aw_valid && aw_ready) begin
                wr_addr = aw_addr;
                got_aw  = 1'b1;
            end
            if (w_valid && w_ready) begin
                wr_line = w_data;
                got_w   = 1'b1;
            end
            if (got_aw && got_w) begin
                mem[wr_addr] = wr_line;
                got_aw = 1'b0;
                got_w  = 1'b0;
                b_wait = 1 + int'($unsigned($random(seed)) % 4);
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end else if (b_wait > 0) begin
                b_wait = b_wait - 1;
                if (b_wait == 0) b_valid <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/l2_cache.sv
`timescale 1ns/1ps
`include "l2_settings.svh"

module l2_cache (
    input  logic          clock,
    input  logic          reset,
    input  logic          req_valid,
    input  logic          req_write,
    input  l2_pkg::addr_t req_addr,
    input  l2_pkg::line_t req_data,
    output logic          resp_valid,
    output l2_pkg::addr_t resp_addr,
    output l2_pkg::line_t resp_data,
    output logic          busy,
    output logic          ar_valid,
    input  logic          ar_ready,
    output l2_pkg::addr_t ar_addr,
    input  logic          r_valid,
    output logic          r_ready,
    input  l2_pkg::line_t r_data,
    output logic          aw_valid,
    input  logic          aw_ready,
    output l2_pkg::addr_t aw_addr,
    output logic          w_valid,
    input  logic          w_ready,
    output l2_pkg::line_t w_data,
    input  logic          b_valid,
    output logic          b_ready
);
    import l2_pkg::*;

    // way slices
    logic                  rd_en, wr_dirty;
    set_idx_t              rd_set, wr_set, set_idx;
    tag_t                  lookup_tag, wr_tag;
    logic [`L2_WAYS-1:0]   hit, rd_dirty, wr_en;
    line_t [`L2_WAYS-1:0]  rd_data;
    tag_t [`L2_WAYS-1:0]   rd_tag;
    line_t                 wr_data, wb_line;
    // replacement, miss queue and write-back
    logic                  touch_en, push, pending, full, empty, pop, wb_start, buffer_busy;
    way_idx_t              touch_way, victim_way;
    addr_t                 push_addr, match_addr, head_addr, wb_addr;

    l2_control u_control (.*);

    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        l2_way_slice u_way (
            .clock, .reset, .rd_en, .rd_set, .lookup_tag,
            .hit      (hit[w]),
            .rd_data  (rd_data[w]),
            .rd_tag   (rd_tag[w]),
            .rd_dirty (rd_dirty[w]),
            .wr_en    (wr_en[w]),
            .wr_set, .wr_tag, .wr_data, .wr_dirty
        );
    end

    l2_lru u_lru (.clock, .reset, .set_idx, .touch_en, .touch_way, .victim_way);

    l2_mshr_queue u_mshr (
        .clock, .reset, .push, .push_addr, .match_addr, .pending, .full, .empty,
        .head_addr, .pop, .ar_valid, .ar_ready, .ar_addr
    );

    l2_writeback u_wb (
        .clock, .reset, .wb_start, .wb_addr, .wb_line, .buffer_busy,
        .aw_valid, .aw_ready, .aw_addr, .w_valid, .w_ready, .w_data, .b_valid, .b_ready
    );

endmodule

//--- rtl/l2_control.sv
`timescale 1ns/1ps
`include "l2_settings.svh"

module l2_control (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         req_valid,
    input  logic                         req_write,
    input  l2_pkg::addr_t                req_addr,
    input  l2_pkg::line_t                req_data,
    output logic                         resp_valid,
    output l2_pkg::addr_t                resp_addr,
    output l2_pkg::line_t                resp_data,
    output logic                         busy,
    input  logic                         r_valid,
    output logic                         r_ready,
    input  l2_pkg::line_t                r_data,
    output logic                         rd_en,
    output l2_pkg::set_idx_t             rd_set,
    output l2_pkg::tag_t                 lookup_tag,
    input  logic [`L2_WAYS-1:0]          hit,
    input  l2_pkg::line_t [`L2_WAYS-1:0] rd_data,
    input  l2_pkg::tag_t [`L2_WAYS-1:0]  rd_tag,
    input  logic [`L2_WAYS-1:0]          rd_dirty,
    output logic [`L2_WAYS-1:0]          wr_en,
    output l2_pkg::set_idx_t             wr_set,
    output l2_pkg::tag_t                 wr_tag,
    output l2_pkg::line_t                wr_data,
    output logic                         wr_dirty,
    output logic                         touch_en,
    output l2_pkg::way_idx_t             touch_way,
    output l2_pkg::set_idx_t             set_idx,
    input  l2_pkg::way_idx_t             victim_way,
    output logic                         push,
    output l2_pkg::addr_t                push_addr,
    output l2_pkg::addr_t                match_addr,
    input  logic                         pending,
    input  logic                         full,
    input  logic                         empty,
    input  l2_pkg::addr_t                head_addr,
    output logic                         pop,
    output logic                         wb_start,
    output l2_pkg::addr_t                wb_addr,
    output l2_pkg::line_t                wb_line,
    input  logic                         buffer_busy
);
    import l2_pkg::*;

    localparam int SET_BITS = $bits(set_idx_t);

    logic        lk_valid, lk_write, hold_valid, hold_write;
    addr_t       lk_addr, hold_addr, rd_addr, cur_addr;
    line_t       lk_data, hold_data, fill_line, resp_data_d;
    fill_state_t fill_state;
    logic        fill_busy, reissue, start, hit_any, need_wb;
    logic        lk_done, to_hold, resp_fire;
    way_idx_t    hit_way, way_sel;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (hit[w]) hit_way = way_idx_t'(w);
        end
    end

    assign hit_any   = |hit;
    assign way_sel   = hit_any ? hit_way : victim_way;    // fills never hit
    assign need_wb   = !hit_any && rd_dirty[victim_way];
    assign fill_busy = (fill_state != FILL_IDLE);

    // a held request retries once its miss has left the queue
    assign match_addr = lk_valid ? lk_addr : hold_addr;
    assign reissue    = hold_valid && !lk_valid && !pending && !fill_busy;
    assign start      = req_valid || reissue;
    assign busy       = lk_valid || hold_valid || full || fill_busy;
    assign r_ready    = !fill_busy && !start && !lk_valid && !empty;

    // ------------------------------------------------------------------------
    // array read port, shared by lookups and fills
    // ------------------------------------------------------------------------
    assign rd_addr    = (fill_state == FILL_READ) ? head_addr : hold_valid ? hold_addr : req_addr;
    assign rd_en      = start || (fill_state == FILL_READ);
    assign rd_set     = set_idx_t'(rd_addr);
    assign lookup_tag = tag_t'(rd_addr >> SET_BITS);

    // install and lookup never overlap, so one address serves both
    assign cur_addr  = fill_busy ? head_addr : lk_addr;
    assign set_idx   = set_idx_t'(cur_addr);
    assign wr_set    = set_idx;
    assign wr_tag    = tag_t'(cur_addr >> SET_BITS);
    assign wr_data   = fill_busy ? fill_line : lk_data;
    assign wr_dirty  = !fill_busy;      // fills go in clean
    assign touch_way = way_sel;
    assign push_addr = lk_addr;
    assign wb_addr   = {rd_tag[victim_way], set_idx};
    assign wb_line   = rd_data[victim_way];

    always_comb begin
        wr_en       = '0;
        touch_en    = 1'b0;
        push        = 1'b0;
        pop         = 1'b0;
        wb_start    = 1'b0;
        lk_done     = 1'b0;
        to_hold     = 1'b0;
        resp_fire   = 1'b0;
        resp_data_d = wr_data;
        if (fill_state == FILL_INSTALL) begin
            if (!(need_wb && buffer_busy)) begin   // dirty victim waits for the buffer
                wr_en[way_sel] = 1'b1;
                touch_en       = 1'b1;
                pop            = 1'b1;
                wb_start       = need_wb;
                resp_fire      = 1'b1;
            end
        end else if (lk_valid) begin
            if (pending) begin
                to_hold = 1'b1;
                lk_done = 1'b1;
            end else if (lk_write) begin
                if (!(need_wb && buffer_busy)) begin   // hit way, else victim way
                    wr_en[way_sel] = 1'b1;
                    touch_en       = 1'b1;
                    wb_start       = need_wb;
                    resp_fire      = 1'b1;
                    lk_done        = 1'b1;
                end
            end else if (hit_any) begin
                touch_en    = 1'b1;
                resp_data_d = rd_data[hit_way];
                resp_fire   = 1'b1;
                lk_done     = 1'b1;
            end else if (!buffer_busy) begin
                // no ar while a victim may still be on its way to DRAM
                push    = 1'b1;
                lk_done = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            lk_valid   <= 1'b0;
            hold_valid <= 1'b0;
            fill_state <= FILL_IDLE;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= resp_fire;
            if (start) lk_valid <= 1'b1;
            else if (lk_done) lk_valid <= 1'b0;
            if (to_hold) hold_valid <= 1'b1;
            else if (reissue) hold_valid <= 1'b0;
            case (fill_state)
                FILL_IDLE: if (r_valid && r_ready) fill_state <= FILL_READ;
                FILL_READ: fill_state <= FILL_INSTALL;
                default:   if (pop) fill_state <= FILL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            lk_write <= hold_valid ? hold_write : req_write;
            lk_addr  <= rd_addr;
            lk_data  <= hold_valid ? hold_data : req_data;
        end
        if (to_hold) begin
            hold_write <= lk_write;
            hold_addr  <= lk_addr;
            hold_data  <= lk_data;
        end
        if (r_valid && r_ready) fill_line <= r_data;
        if (resp_fire) begin
            resp_addr <= cur_addr;
            resp_data <= resp_data_d;   // written line echoes back on writes
        end
    end

endmodule

//--- rtl/l2_writeback.sv
`timescale 1ns/1ps
`include "l2_settings.svh"

module l2_writeback (
    input  logic          clock,
    input  logic          reset,
    input  logic          wb_start,
    input  l2_pkg::addr_t wb_addr,
    input  l2_pkg::line_t wb_line,
    output logic          buffer_busy,
    output logic          aw_valid,
    input  logic          aw_ready,
    output l2_pkg::addr_t aw_addr,
    output logic          w_valid,
    input  logic          w_ready,
    output l2_pkg::line_t w_data,
    input  logic          b_valid,
    output logic          b_ready
);
    import l2_pkg::*;

    wb_state_t state;

    assign buffer_busy = (state != WB_IDLE);
    assign b_ready     = (state == WB_WAIT_RESP);

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= WB_IDLE;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (wb_start) begin
                        state    <= WB_SEND;
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                    end
                end
                WB_SEND: begin
                    // aw and w may complete in either order
                    if (aw_ready) aw_valid <= 1'b0;
                    if (w_ready) w_valid <= 1'b0;
                    if ((!aw_valid || aw_ready) && (!w_valid || w_ready)) state <= WB_WAIT_RESP;
                end
                default: begin
                    if (b_valid) state <= WB_IDLE;   // buffer free again
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (wb_start && state == WB_IDLE) begin
            aw_addr <= wb_addr;
            w_data  <= wb_line;
        end
    end

endmodule

//--- rtl/l2_mshr_queue.sv
`timescale 1ns/1ps
`include "l2_settings.svh"

module l2_mshr_queue (
    input  logic          clock,
    input  logic          reset,
    input  logic          push,
    input  l2_pkg::addr_t push_addr,
    input  l2_pkg::addr_t match_addr,
    output logic          pending,
    output logic          full,
    output logic          empty,
    output l2_pkg::addr_t head_addr,
    input  logic          pop,
    output logic          ar_valid,
    input  logic          ar_ready,
    output l2_pkg::addr_t ar_addr
);
    import l2_pkg::*;

    logic [`L2_NUM_MSHRS-1:0] entry_valid;
    logic [`L2_NUM_MSHRS-1:0] sent;        // address already went out on ar
    addr_t                    addrs [`L2_NUM_MSHRS];

    mshr_idx_t free_idx;    // next slot to fill
    mshr_idx_t issue_idx;   // next slot to send on ar
    mshr_idx_t wait_idx;    // oldest slot, waits for its r beat

    assign full      = entry_valid[free_idx];
    assign empty     = !entry_valid[wait_idx];
    assign head_addr = addrs[wait_idx];

    // ar follows push order, and DRAM answers in ar order
    assign ar_valid = entry_valid[issue_idx] && !sent[issue_idx];
    assign ar_addr  = addrs[issue_idx];

    always_comb begin
        pending = 1'b0;
        for (int i = 0; i < `L2_NUM_MSHRS; i++) begin
            if (entry_valid[i] && addrs[i] == match_addr) pending = 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // indices and status bits
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            sent        <= '0;
            free_idx    <= '0;
            issue_idx   <= '0;
            wait_idx    <= '0;
        end else begin
            if (push) begin
                entry_valid[free_idx] <= 1'b1;
                free_idx              <= free_idx + 1'b1;
            end
            if (ar_valid && ar_ready) begin
                sent[issue_idx] <= 1'b1;
                issue_idx       <= issue_idx + 1'b1;
            end
            if (pop) begin     // head was sent long ago, no clash with the issue side
                entry_valid[wait_idx] <= 1'b0;
                sent[wait_idx]        <= 1'b0;
                wait_idx              <= wait_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) addrs[free_idx] <= push_addr;
    end

endmodule

//--- rtl/l2_lru.sv
`timescale 1ns/1ps
`include "l2_settings.svh"

module l2_lru (
    input  logic             clock,
    input  logic             reset,
    input  l2_pkg::set_idx_t set_idx,
    input  logic             touch_en,
    input  l2_pkg::way_idx_t touch_way,
    output l2_pkg::way_idx_t victim_way
);
    import l2_pkg::*;

    age_t ages [`L2_NUM_SETS][`L2_WAYS];
    age_t touched_age;

    assign touched_age = ages[set_idx][touch_way];

    // exactly one way per set sits at age zero
    always_comb begin
        victim_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (ages[set_idx][w] == '0) victim_way = way_idx_t'(w);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `L2_NUM_SETS; s++) begin
                for (int w = 0; w < `L2_WAYS; w++) begin
                    ages[s][w] <= age_t'(w);
                end
            end
        end else if (touch_en) begin
            // touched way becomes newest, the ways above it move down one
            for (int w = 0; w < `L2_WAYS; w++) begin
                if (way_idx_t'(w) == touch_way) begin
                    ages[set_idx][w] <= age_t'(`L2_WAYS - 1);
                end else if (ages[set_idx][w] > touched_age) begin
                    ages[set_idx][w] <= ages[set_idx][w] - 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/l2_way_slice.sv
`timescale 1ns/1ps
`include "l2_settings.svh"

module l2_way_slice (
    input  logic             clock,
    input  logic             reset,
    input  logic             rd_en,
    input  l2_pkg::set_idx_t rd_set,
    input  l2_pkg::tag_t     lookup_tag,
    output logic             hit,
    output l2_pkg::line_t    rd_data,
    output l2_pkg::tag_t     rd_tag,
    output logic             rd_dirty,
    input  logic             wr_en,
    input  l2_pkg::set_idx_t wr_set,
    input  l2_pkg::tag_t     wr_tag,
    input  l2_pkg::line_t    wr_data,
    input  logic             wr_dirty
);
    import l2_pkg::*;

    line_t                   data_mem [`L2_NUM_SETS];
    tag_t                    tag_mem  [`L2_NUM_SETS];
    logic [`L2_NUM_SETS-1:0] valid_bits;
    logic [`L2_NUM_SETS-1:0] dirty_bits;

    tag_t lookup_q;     // tag that came with the read
    logic valid_q;
    logic dirty_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
            valid_q    <= 1'b0;
        end else begin
            if (wr_en) valid_bits[wr_set] <= 1'b1;
            if (rd_en) valid_q <= valid_bits[rd_set];
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            data_mem[wr_set]   <= wr_data;
            tag_mem[wr_set]    <= wr_tag;
            dirty_bits[wr_set] <= wr_dirty;
        end
        if (rd_en) begin    // outputs hold between reads
            rd_data  <= data_mem[rd_set];
            rd_tag   <= tag_mem[rd_set];
            dirty_q  <= dirty_bits[rd_set];
            lookup_q <= lookup_tag;
        end
    end

    assign hit      = valid_q && (rd_tag == lookup_q);
    assign rd_dirty = valid_q && dirty_q;   // an empty way never needs write-back

endmodule

//--- rtl/l2_pkg.sv
`include "l2_settings.svh"

package l2_pkg;

    // address split is {tag, set}, the set index sits in the low bits
    typedef logic [`L2_ADDR_BITS-1:0] addr_t;
    typedef logic [`L2_LINE_BITS-1:0] line_t;
    typedef logic [$clog2(`L2_NUM_SETS)-1:0] set_idx_t;
    typedef logic [`L2_ADDR_BITS-$clog2(`L2_NUM_SETS)-1:0] tag_t;

    typedef logic [$clog2(`L2_WAYS)-1:0] way_idx_t;
    typedef logic [$clog2(`L2_WAYS)-1:0] age_t;      // highest age is most recent
    typedef logic [$clog2(`L2_NUM_MSHRS)-1:0] mshr_idx_t;

    // line fill: r beat taken, set read, then install
    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_READ,
        FILL_INSTALL
    } fill_state_t;

    // victim write-back over aw/w, then wait for b
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_SEND,
        WB_WAIT_RESP
    } wb_state_t;

endpackage

//--- rtl/l2_settings.svh
`ifndef L2_SETTINGS_SVH
`define L2_SETTINGS_SVH

// ---------------------------------------------------------------------------
// cache geometry
// ---------------------------------------------------------------------------
`define L2_WAYS       4     // ways per set
`define L2_NUM_SETS   16
`define L2_LINE_BITS  64    // a whole line moves in one beat
`define L2_ADDR_BITS  16    // line address, no byte offset

// ---------------------------------------------------------------------------
// miss handling
// ---------------------------------------------------------------------------
`define L2_NUM_MSHRS  4     // keep a power of two, the indices wrap freely

`endif
